//--- design/rtc_cfg.svh
// RTC register block constants: include wherever word offsets, widths or control bit positions are needed
`ifndef RTC_CFG_SVH
`define RTC_CFG_SVH

// ------------------------------
// Bus geometry
// ------------------------------
`define RTC_DATA_W      32      // Register word width
`define RTC_ADDR_W      5       // Byte address, 8 words max
`define RTC_NUM_ALARMS  2       // Alarm comparators
`define RTC_CTRL_RST    16'h400 // 24-hour mode out of reset

// ------------------------------
// Word indices, addr[4:2]
// ------------------------------
`define RTC_REG_CMD     3'd0
`define RTC_REG_TIME    3'd1
`define RTC_REG_DATE    3'd2
`define RTC_REG_ALRM1   3'd3
`define RTC_REG_ALRM2   3'd4
`define RTC_REG_CTRL    3'd5

// Control word fields
`define RTC_CTRL_A1_MODE_LSB  0   // Alarm 1 mode, 4 bits
`define RTC_CTRL_A2_MODE_LSB  4   // Alarm 2 mode, 4 bits
`define RTC_CTRL_IE_LSB       8   // One enable per alarm
`define RTC_CTRL_HMODE        10  // 1 = 24 hour
`define RTC_CTRL_HALT         11
`define RTC_CTRL_RESET        12
`define RTC_CTRL_STAT_LSB     16  // Sticky status, W1C

`endif

//--- design/rtc_reg_pkg.sv
// Register bus and register map types for the RTC block; import where bus words or alarm vectors are used
`include "rtc_cfg.svh"

package rtc_reg_pkg;

  // ------------------------------
  // Bus payloads
  // ------------------------------
  typedef logic [`RTC_DATA_W-1:0]   reg_word_t;  // One data word
  typedef logic [`RTC_DATA_W/8-1:0] reg_be_t;    // Byte lanes
  typedef logic [`RTC_ADDR_W-1:0]   reg_addr_t;  // Byte address

  // Word select, taken from addr[4:2]
  typedef enum logic [2:0] {
    REG_CMD   = `RTC_REG_CMD,   // Write-only pulses
    REG_TIME  = `RTC_REG_TIME,
    REG_DATE  = `RTC_REG_DATE,
    REG_ALRM1 = `RTC_REG_ALRM1,
    REG_ALRM2 = `RTC_REG_ALRM2,
    REG_CTRL  = `RTC_REG_CTRL   // Modes, enables, status
  } reg_sel_e;

  // One bit per alarm
  // used for hit, status, enable and clear
  typedef logic [`RTC_NUM_ALARMS-1:0] alarm_vec_t;

endpackage

//--- design/rtc_time_pkg.sv
// BCD time and date word layouts and alarm modes; import wherever time digits are packed or compared
package rtc_time_pkg;

  typedef logic [3:0] bcd_digit_t;  // One BCD digit

  // Alarm modes, undefined codes behave as off
  typedef enum logic [3:0] {
    ALM_OFF        = 4'd0,
    ALM_EVERY_SEC  = 4'd1,  // Follows inc_time_s
    ALM_EVERY_MIN  = 4'd2,  // Follows inc_time_m
    ALM_EVERY_HOUR = 4'd3,  // Follows inc_time_h
    ALM_MATCH_S    = 4'd4,  // Seconds equal
    ALM_MATCH_SM   = 4'd5,  // Plus minutes
    ALM_MATCH_SMH  = 4'd6   // Plus hours
  } alarm_mode_e;

  // ------------------------------
  // Time word, also the alarm word
  // ------------------------------
  typedef struct packed {
    logic [4:0] rsvd3;  // 31:27
    logic [2:0] dow;    // 26:24
    logic [1:0] rsvd2;  // 23:22
    logic [1:0] th;     // 21:20
    bcd_digit_t h;      // 19:16
    logic       rsvd1;  // 15
    logic [2:0] tm;     // 14:12
    bcd_digit_t m;      // 11:8
    logic       rsvd0;  // 7
    logic [2:0] ts;     // 6:4
    bcd_digit_t s;      // 3:0
  } time_word_t;

  // Date word
  typedef struct packed {
    bcd_digit_t tc;     // 31:28 ten centuries
    bcd_digit_t c;      // 27:24
    bcd_digit_t ty;     // 23:20
    bcd_digit_t y;      // 19:16
    logic [2:0] rsvd1;  // 15:13
    logic       tm;     // 12
    bcd_digit_t m;      // 11:8
    logic [1:0] rsvd0;  // 7:6
    logic [1:0] td;     // 5:4
    bcd_digit_t d;      // 3:0
  } date_word_t;

endpackage

//--- design/rtc_reg_file.sv
// RTC register file: bus decode, byte-enabled storage, command and clear strobes, readback mux
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module rtc_reg_file
  import rtc_reg_pkg::*;
  import rtc_time_pkg::*;
(
  input  logic                                   rtc_clk,
  input  logic                                   rst_n,
  // Register bus
  input  logic                                   reg_cs,
  input  logic                                   reg_wr,
  input  reg_addr_t                              reg_addr,
  input  reg_word_t                              reg_wdata,
  input  reg_be_t                                reg_be,
  output reg_word_t                              reg_rdata,
  output logic                                   reg_ack,
  // Live counters from the time core
  input  bcd_digit_t                             time_s,
  input  logic [2:0]                             time_ts,
  input  bcd_digit_t                             time_m,
  input  logic [2:0]                             time_tm,
  input  bcd_digit_t                             time_h,
  input  logic [1:0]                             time_th,
  input  logic [2:0]                             time_dow,
  input  bcd_digit_t                             date_d,
  input  logic [1:0]                             date_td,
  input  bcd_digit_t                             date_m,
  input  logic                                   date_tm,
  input  bcd_digit_t                             date_y,
  input  bcd_digit_t                             date_ty,
  input  bcd_digit_t                             date_c,
  input  bcd_digit_t                             date_tc,
  // Alarm and interrupt side
  input  alarm_vec_t                             intr_stat,
  output alarm_mode_e [`RTC_NUM_ALARMS-1:0]      alarm_mode,
  output reg_word_t   [`RTC_NUM_ALARMS-1:0]      alarm_word,
  output alarm_vec_t                             intr_ie,
  output alarm_vec_t                             intr_clr,
  // Time core control
  output logic                                   cfg_rtc_update,
  output logic                                   cfg_rtc_capture,
  output logic                                   cfg_rtc_halt,
  output logic                                   cfg_rtc_reset,
  output logic                                   cfg_hmode,
  output reg_word_t                              cfg_time,
  output reg_word_t                              cfg_date
);

  reg_sel_e                        reg_sel;     // Decoded word
  logic                            wr_en;       // One write per access
  logic                            cmd_wr, time_wr, date_wr, ctrl_wr;
  logic                            capture_wr;  // Capture request this cycle
  logic [`RTC_CTRL_STAT_LSB-1:0]   ctrl_q;      // Control bits 15:0
  reg_word_t                       ctrl_next;
  reg_word_t                       rd_word;
  time_word_t                      live_time;
  date_word_t                      live_date;

  // Keep old bytes where the lane is off
  function automatic reg_word_t be_merge(reg_word_t old_w, reg_word_t new_w, reg_be_t be);
    reg_word_t res;
    res = old_w;
    for (int b = 0; b < `RTC_DATA_W/8; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // ------------------------------
  // Decode and ack
  // ------------------------------
  assign reg_sel    = reg_sel_e'(reg_addr[`RTC_ADDR_W-1:2]);
  assign wr_en      = reg_cs & reg_wr & ~reg_ack;  // Not repeated in the ack cycle
  assign cmd_wr     = wr_en && (reg_sel == REG_CMD);
  assign time_wr    = wr_en && (reg_sel == REG_TIME);
  assign date_wr    = wr_en && (reg_sel == REG_DATE);
  assign ctrl_wr    = wr_en && (reg_sel == REG_CTRL);
  assign capture_wr = cmd_wr & reg_be[0] & reg_wdata[1];

  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= reg_cs & ~reg_ack;  // Exactly one cycle per access
    end
  end

  // Read data lands with ack
  always_ff @(posedge rtc_clk) begin
    if (reg_cs && !reg_ack) reg_rdata <= rd_word;
  end

  // Update and capture strobes, coincide with ack
  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_rtc_update  <= 1'b0;
      cfg_rtc_capture <= 1'b0;
    end else begin
      cfg_rtc_update  <= cmd_wr & reg_be[0] & reg_wdata[0];
      cfg_rtc_capture <= capture_wr;
    end
  end

  // Live digits in register layout
  always_comb begin
    live_time     = '0;
    live_time.s   = time_s;
    live_time.ts  = time_ts;
    live_time.m   = time_m;
    live_time.tm  = time_tm;
    live_time.h   = time_h;
    live_time.th  = time_th;
    live_time.dow = time_dow;
    live_date     = '0;
    live_date.d   = date_d;
    live_date.td  = date_td;
    live_date.m   = date_m;
    live_date.tm  = date_tm;
    live_date.y   = date_y;
    live_date.ty  = date_ty;
    live_date.c   = date_c;
    live_date.tc  = date_tc;
  end

  // ------------------------------
  // Storage
  // ------------------------------
  assign ctrl_next = be_merge(reg_word_t'(ctrl_q), reg_wdata, reg_be);

  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_time   <= '0;
      cfg_date   <= '0;
      alarm_word <= '0;
      ctrl_q     <= `RTC_CTRL_RST;
    end else begin
      if (capture_wr) begin  // Command write, never a time/date write
        cfg_time <= live_time;
        cfg_date <= live_date;
      end
      if (time_wr) cfg_time <= be_merge(cfg_time, reg_wdata, reg_be);
      if (date_wr) cfg_date <= be_merge(cfg_date, reg_wdata, reg_be);
      if (wr_en && reg_sel == REG_ALRM1) alarm_word[0] <= be_merge(alarm_word[0], reg_wdata, reg_be);
      if (wr_en && reg_sel == REG_ALRM2) alarm_word[1] <= be_merge(alarm_word[1], reg_wdata, reg_be);
      if (ctrl_wr) ctrl_q <= ctrl_next[`RTC_CTRL_STAT_LSB-1:0];  // Upper lanes are W1C
    end
  end

  // Control fields out
  assign alarm_mode[0] = alarm_mode_e'(ctrl_q[`RTC_CTRL_A1_MODE_LSB +: 4]);
  assign alarm_mode[1] = alarm_mode_e'(ctrl_q[`RTC_CTRL_A2_MODE_LSB +: 4]);
  assign intr_ie       = ctrl_q[`RTC_CTRL_IE_LSB +: `RTC_NUM_ALARMS];
  assign cfg_hmode     = ctrl_q[`RTC_CTRL_HMODE];
  assign cfg_rtc_halt  = ctrl_q[`RTC_CTRL_HALT];
  assign cfg_rtc_reset = ctrl_q[`RTC_CTRL_RESET];

  // Status clear strobe, status drops at the ack edge
  assign intr_clr = {`RTC_NUM_ALARMS{ctrl_wr & reg_be[`RTC_CTRL_STAT_LSB/8]}}
                  & reg_wdata[`RTC_CTRL_STAT_LSB +: `RTC_NUM_ALARMS];

  // Readback mux
  always_comb begin
    case (reg_sel)
      REG_TIME:  rd_word = cfg_time;
      REG_DATE:  rd_word = cfg_date;
      REG_ALRM1: rd_word = alarm_word[0];
      REG_ALRM2: rd_word = alarm_word[1];
      REG_CTRL:  rd_word = {{(`RTC_DATA_W-`RTC_CTRL_STAT_LSB-`RTC_NUM_ALARMS){1'b0}},
                            intr_stat, ctrl_q};
      default:   rd_word = '0;  // CMD and unmapped words
    endcase
  end

endmodule

//--- design/rtc_alarm_unit.sv
// One RTC alarm comparator: periodic pulse or digit match by mode, instantiated once per alarm
`timescale 1ns/1ps

module rtc_alarm_unit
  import rtc_reg_pkg::*;
  import rtc_time_pkg::*;
(
  input  alarm_mode_e  alarm_mode,
  input  reg_word_t    alarm_word,  // Same layout as the time word
  // Increment pulses from the time core
  input  logic         inc_time_s,
  input  logic         inc_time_m,
  input  logic         inc_time_h,
  // Live time digits
  input  bcd_digit_t   time_s,
  input  logic [2:0]   time_ts,
  input  bcd_digit_t   time_m,
  input  logic [2:0]   time_tm,
  input  bcd_digit_t   time_h,
  input  logic [1:0]   time_th,
  output logic         alarm_hit    // Combinational
);

  time_word_t alm;
  logic       match_s, match_m, match_h;

  assign alm = time_word_t'(alarm_word);

  // ------------------------------
  // Per-field digit compares
  // ------------------------------
  assign match_s = (alm.s == time_s) && (alm.ts == time_ts);
  assign match_m = (alm.m == time_m) && (alm.tm == time_tm);
  assign match_h = (alm.h == time_h) && (alm.th == time_th);  // Hours vs hour digits

  // Mode select
  always_comb begin
    case (alarm_mode)
      ALM_OFF:        alarm_hit = 1'b0;
      ALM_EVERY_SEC:  alarm_hit = inc_time_s;
      ALM_EVERY_MIN:  alarm_hit = inc_time_m;
      ALM_EVERY_HOUR: alarm_hit = inc_time_h;
      ALM_MATCH_S:    alarm_hit = match_s;
      ALM_MATCH_SM:   alarm_hit = match_s & match_m;
      ALM_MATCH_SMH:  alarm_hit = match_s & match_m & match_h;
      default:        alarm_hit = 1'b0;  // Spare codes
    endcase
  end

  // Match modes stay high for the whole matching second;
  // the sticky status downstream turns that into one event

endmodule

//--- design/rtc_irq_ctrl.sv
// RTC alarm interrupt control: sticky per-alarm status, write-one clear and masked interrupt line
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module rtc_irq_ctrl
  import rtc_reg_pkg::*;
(
  input  logic        rtc_clk,
  input  logic        rst_n,
  input  alarm_vec_t  alarm_hit,  // Raw hits, combinational
  input  alarm_vec_t  intr_clr,   // W1C strobe from the bus
  input  alarm_vec_t  intr_ie,    // Enables from control
  output alarm_vec_t  intr_stat,  // Sticky status
  output logic        rtc_intr
);

  // ------------------------------
  // Sticky status
  // ------------------------------
  // Normal cycle: OR in the hit
  // Clear cycle: load the hit, so a new hit beats the clear
  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      intr_stat <= '0;
    end else begin
      for (int i = 0; i < `RTC_NUM_ALARMS; i++) begin
        if (intr_clr[i]) begin
          intr_stat[i] <= alarm_hit[i];
        end else begin
          intr_stat[i] <= intr_stat[i] | alarm_hit[i];
        end
      end
    end
  end

  // Level output from status, one cycle after the hit
  assign rtc_intr = |(intr_stat & intr_ie);

endmodule

//--- design/rtc_reg_top.sv
// RTC register block top: register file, one alarm unit per alarm and the interrupt controller
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module rtc_reg_top
  import rtc_reg_pkg::*;
  import rtc_time_pkg::*;
(
  input  logic        rtc_clk,
  input  logic        rst_n,
  // Register bus
  input  logic        reg_cs,
  input  logic        reg_wr,
  input  reg_addr_t   reg_addr,
  input  reg_word_t   reg_wdata,
  input  reg_be_t     reg_be,
  output reg_word_t   reg_rdata,
  output logic        reg_ack,
  // Increment pulses
  input  logic        inc_time_s,
  input  logic        inc_time_m,
  input  logic        inc_time_h,
  // Live time and date digits
  input  bcd_digit_t  time_s,
  input  logic [2:0]  time_ts,
  input  bcd_digit_t  time_m,
  input  logic [2:0]  time_tm,
  input  bcd_digit_t  time_h,
  input  logic [1:0]  time_th,
  input  logic [2:0]  time_dow,
  input  bcd_digit_t  date_d,
  input  logic [1:0]  date_td,
  input  bcd_digit_t  date_m,
  input  logic        date_tm,
  input  bcd_digit_t  date_y,
  input  bcd_digit_t  date_ty,
  input  bcd_digit_t  date_c,
  input  bcd_digit_t  date_tc,
  // Time core control
  output logic        cfg_rtc_update,
  output logic        cfg_rtc_capture,
  output logic        cfg_rtc_halt,
  output logic        cfg_rtc_reset,
  output logic        cfg_hmode,
  output reg_word_t   cfg_time,
  output reg_word_t   cfg_date,
  output logic        rtc_intr
);

  alarm_mode_e [`RTC_NUM_ALARMS-1:0] alarm_mode;
  reg_word_t   [`RTC_NUM_ALARMS-1:0] alarm_word;
  alarm_vec_t                        alarm_hit;
  alarm_vec_t                        intr_stat, intr_ie, intr_clr;

  // ------------------------------
  // Register file
  // ------------------------------
  rtc_reg_file u_reg_file (
    .rtc_clk, .rst_n,
    .reg_cs, .reg_wr, .reg_addr, .reg_wdata, .reg_be, .reg_rdata, .reg_ack,
    .time_s, .time_ts, .time_m, .time_tm, .time_h, .time_th, .time_dow,
    .date_d, .date_td, .date_m, .date_tm, .date_y, .date_ty, .date_c, .date_tc,
    .intr_stat, .alarm_mode, .alarm_word, .intr_ie, .intr_clr,
    .cfg_rtc_update, .cfg_rtc_capture, .cfg_rtc_halt, .cfg_rtc_reset,
    .cfg_hmode, .cfg_time, .cfg_date
  );

  // One comparator per alarm
  for (genvar i = 0; i < `RTC_NUM_ALARMS; i++) begin : g_alarm
    rtc_alarm_unit u_alarm (
      .alarm_mode (alarm_mode[i]),
      .alarm_word (alarm_word[i]),
      .inc_time_s, .inc_time_m, .inc_time_h,
      .time_s, .time_ts, .time_m, .time_tm, .time_h, .time_th,
      .alarm_hit  (alarm_hit[i])
    );
  end

  // Status and interrupt line
  rtc_irq_ctrl u_irq_ctrl (
    .rtc_clk, .rst_n,
    .alarm_hit, .intr_clr, .intr_ie, .intr_stat, .rtc_intr
  );

endmodule

//--- tests/rtc_reg_checker.sv
// Concurrent checks on the RTC register block bus ack, strobes and interrupt; bound to the top level
`timescale 1ns/1ps

module rtc_reg_checker
  import rtc_reg_pkg::*;
(
  input logic       rtc_clk,
  input logic       rst_n,
  input logic       reg_ack,
  input logic       cfg_rtc_update,
  input logic       cfg_rtc_capture,
  input alarm_vec_t alarm_hit,   // Raw hits inside the top
  input alarm_vec_t intr_ie,
  input logic       rtc_intr
);

  // ------------------------------
  // Bus
  // ------------------------------
  ack_single: assert property (@(posedge rtc_clk) disable iff (!rst_n)
    reg_ack |=> !reg_ack)
    else $error("reg_ack high in two consecutive cycles");

  // Interrupt rises only after an enabled hit or an enable change
  intr_rise_cause: assert property (@(posedge rtc_clk) disable iff (!rst_n)
    $rose(rtc_intr) |-> ($past(alarm_hit & intr_ie) != '0) || (intr_ie != $past(intr_ie)))
    else $error("rtc_intr rose without an enabled hit in the previous cycle");

  // Time core strobes are single pulses
  strobe_single: assert property (@(posedge rtc_clk) disable iff (!rst_n)
    (cfg_rtc_update || cfg_rtc_capture) |=> !(cfg_rtc_update || cfg_rtc_capture))
    else $error("Update or capture strobe high in consecutive cycles");

endmodule

bind rtc_reg_top rtc_reg_checker u_checker (
  .rtc_clk         (rtc_clk),
  .rst_n           (rst_n),
  .reg_ack         (reg_ack),
  .cfg_rtc_update  (cfg_rtc_update),
  .cfg_rtc_capture (cfg_rtc_capture),
  .alarm_hit       (alarm_hit),
  .intr_ie         (intr_ie),
  .rtc_intr        (rtc_intr)
);

//--- tests/rtc_reg_tb.sv
// Directed testbench for the RTC register block; runs reset, bus, command, alarm and control tests
`timescale 1ns/1ps
`include "rtc_cfg.svh"

module rtc_reg_tb
  import rtc_reg_pkg::*;
  import rtc_time_pkg::*;
();

  localparam int MAX_CYCLES = 2000;  // Several times the whole run
  localparam int ACK_WAIT   = 16;    // Per access

  logic        rtc_clk, rst_n;
  logic        reg_cs, reg_wr, reg_ack;
  reg_addr_t   reg_addr;
  reg_word_t   reg_wdata, reg_rdata;
  reg_be_t     reg_be;
  logic        inc_time_s, inc_time_m, inc_time_h;
  bcd_digit_t  time_s, time_m, time_h, date_d, date_m, date_y, date_ty, date_c, date_tc;
  logic [2:0]  time_ts, time_tm, time_dow;
  logic [1:0]  time_th, date_td;
  logic        date_tm;
  logic        cfg_rtc_update, cfg_rtc_capture, cfg_rtc_halt, cfg_rtc_reset, cfg_hmode;
  reg_word_t   cfg_time, cfg_date;
  logic        rtc_intr;

  reg_word_t   shadow [6];                   // Expected register contents
  logic [31:0] rng_state;
  int          cycles, n_pass, n_fail, test_errs;
  int          upd_cnt, cap_cnt, proto_errs;  // Written by the monitor only
  logic        upd_at_ack, ack_q;

  always begin  // 4 ns period
    rtc_clk = 1'b0;
    #2;
    rtc_clk = 1'b1;
    #2;
  end

  rtc_reg_top rtc_reg_top_i (.*);

  // ------------------------------
  // Timeout and strobe monitor
  // ------------------------------
  always @(posedge rtc_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  always @(negedge rtc_clk) begin  // Mid-cycle, outputs settled
    if (cfg_rtc_update) upd_cnt++;
    if (cfg_rtc_capture) cap_cnt++;
    if (rst_n && reg_ack && ack_q) begin
      $display("Error at %0t: reg_ack stayed high for two cycles", $time);
      proto_errs++;
    end
    ack_q = reg_ack;
  end

  function automatic logic [31:0] next_rand();  // xorshift32
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic reg_word_t lane_mask(reg_be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic tally(bit ok);
    if (ok) n_pass++;
    else begin
      n_fail++;
      test_errs++;
    end
  endtask

  task automatic check_word(string name, reg_word_t exp, reg_word_t act);
    if (act !== exp) $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    tally(act === exp);
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    tally(act === exp);
  endtask

  task automatic check_stat(string name, alarm_vec_t exp, alarm_vec_t act);
    if (act !== exp) $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    tally(act === exp);
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) $display("Mismatch at %0t: %s pulse count expected %0d, got %0d",
                             $time, name, exp, act);
    tally(act == exp);
  endtask

  task automatic end_test(string name);
    $display("%s: %s (%0d errors)", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    test_errs = 0;
  endtask

  // ------------------------------
  // Bus and live digit drivers
  // ------------------------------
  task automatic bus_access(logic wr, logic [2:0] idx, reg_word_t data, reg_be_t be,
                            output reg_word_t rdata);
    int waited;
    waited = 0;
    @(posedge rtc_clk);
    #1;
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = {idx, 2'b00};
    reg_wdata = data;
    reg_be    = be;
    do begin
      @(posedge rtc_clk);
      #1;
      waited++;
    end while (!reg_ack && waited < ACK_WAIT);
    if (!reg_ack) begin
      $display("Error at %0t: no ack for access to word %0d", $time, idx);
      tally(1'b0);
    end
    rdata      = reg_rdata;  // Valid with ack
    upd_at_ack = cfg_rtc_update;
    reg_cs     = 1'b0;
    reg_wr     = 1'b0;
  endtask

  task automatic bus_write(logic [2:0] idx, reg_word_t data, reg_be_t be);
    reg_word_t unused;
    bus_access(1'b1, idx, data, be, unused);
  endtask

  task automatic bus_read(logic [2:0] idx, output reg_word_t data);
    bus_access(1'b0, idx, '0, '0, data);
  endtask

  task automatic set_time(reg_word_t w);  // Unpack by the time word layout
    time_s   = w[3:0];
    time_ts  = w[6:4];
    time_m   = w[11:8];
    time_tm  = w[14:12];
    time_h   = w[19:16];
    time_th  = w[21:20];
    time_dow = w[26:24];
  endtask

  task automatic set_date(reg_word_t w);
    date_d  = w[3:0];
    date_td = w[5:4];
    date_m  = w[11:8];
    date_tm = w[12];
    date_y  = w[19:16];
    date_ty = w[23:20];
    date_c  = w[27:24];
    date_tc = w[31:28];
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset();
    reg_word_t rd;
    for (int i = 0; i < 6; i++) begin
      bus_read(i[2:0], rd);
      check_word($sformatf("reg_rdata[word %0d]", i), shadow[i], rd);
    end
    check_bit("cfg_hmode", 1'b1, cfg_hmode);
    check_bit("cfg_rtc_halt", 1'b0, cfg_rtc_halt);
    check_bit("cfg_rtc_reset", 1'b0, cfg_rtc_reset);
    check_bit("rtc_intr", 1'b0, rtc_intr);
    end_test("reset values");
  endtask

  task automatic test_byte_writes();
    reg_word_t  data, rd, mask, r;
    reg_be_t    be;
    logic [2:0] idx;
    for (int n = 0; n < 20; n++) begin
      idx  = 3'(1 + n % 5);  // Time through control
      data = next_rand();
      r    = next_rand();
      be   = r[3:0];
      if (idx == `RTC_REG_CTRL) data = data & 32'hFFFF_FF33;  // Modes 0..3 only, no hits
      mask = lane_mask(be);
      shadow[idx] = (shadow[idx] & ~mask) | (data & mask);
      if (idx == `RTC_REG_CTRL) shadow[idx] = shadow[idx] & 32'h0000_FFFF;  // Status reads 0
      bus_write(idx, data, be);
      bus_read(idx, rd);
      check_word($sformatf("reg_rdata[word %0d]", idx), shadow[idx], rd);
    end
    bus_write(`RTC_REG_CTRL, 32'h0000_0400, 4'hF);
    shadow[`RTC_REG_CTRL] = 32'h0000_0400;
    end_test("byte writes");
  endtask

  task automatic test_command();
    reg_word_t rd, t_w, d_w;
    int        base;
    base = upd_cnt;
    bus_write(`RTC_REG_CMD, 32'h1, 4'h1);
    check_bit("cfg_rtc_update at ack", 1'b1, upd_at_ack);
    repeat (3) @(posedge rtc_clk);  // Room for a stray second pulse
    #1;
    check_count("cfg_rtc_update", 1, upd_cnt - base);
    t_w = next_rand();
    d_w = next_rand();
    set_time(t_w);
    set_date(d_w);
    shadow[`RTC_REG_TIME] = t_w & 32'h073F_7F7F;  // Only the digit fields
    shadow[`RTC_REG_DATE] = d_w & 32'hFFFF_1F3F;
    base = cap_cnt;
    bus_write(`RTC_REG_CMD, 32'h2, 4'h1);
    check_word("cfg_time", shadow[`RTC_REG_TIME], cfg_time);
    check_word("cfg_date", shadow[`RTC_REG_DATE], cfg_date);
    bus_read(`RTC_REG_TIME, rd);
    check_word("reg_rdata[time]", shadow[`RTC_REG_TIME], rd);
    bus_read(`RTC_REG_DATE, rd);
    check_word("reg_rdata[date]", shadow[`RTC_REG_DATE], rd);
    check_count("cfg_rtc_capture", 1, cap_cnt - base);
    end_test("command pulses");
  endtask

  task automatic test_periodic();
    reg_word_t rd;
    bus_write(`RTC_REG_CTRL, 32'h0000_0501, 4'hF);  // Alarm 1 every second, enabled
    check_bit("rtc_intr", 1'b0, rtc_intr);
    inc_time_s = 1'b1;
    #1;
    check_bit("rtc_intr", 1'b0, rtc_intr);  // Hit alone, status not yet set
    @(posedge rtc_clk);
    #1;
    inc_time_s = 1'b0;
    check_bit("rtc_intr", 1'b1, rtc_intr);  // One cycle after the hit
    bus_read(`RTC_REG_CTRL, rd);
    check_stat("intr_stat", 2'b01, rd[17:16]);
    check_bit("rtc_intr", 1'b1, rtc_intr);  // Sticky
    bus_write(`RTC_REG_CTRL, 32'h0001_0000, 4'b0100);  // Write one to clear
    check_bit("rtc_intr", 1'b0, rtc_intr);
    bus_read(`RTC_REG_CTRL, rd);
    check_stat("intr_stat", 2'b00, rd[17:16]);
    check_word("reg_rdata[ctrl]", 32'h0000_0501, rd);
    end_test("periodic alarm");
  endtask

  task automatic test_match();
    reg_word_t rd, alm;
    alm = 32'h0019_5437;  // 19:54:37
    set_time(alm ^ 32'h0001_0000);  // Hour digit off by one
    bus_write(`RTC_REG_ALRM2, alm, 4'hF);
    bus_write(`RTC_REG_CTRL, 32'h0000_0460, 4'hF);  // Alarm 2 full match, enable low
    bus_read(`RTC_REG_CTRL, rd);
    check_stat("intr_stat", 2'b00, rd[17:16]);
    set_time(alm);
    bus_read(`RTC_REG_CTRL, rd);
    check_stat("intr_stat", 2'b10, rd[17:16]);
    check_bit("rtc_intr", 1'b0, rtc_intr);
    set_time(alm ^ 32'h0001_0000);
    bus_write(`RTC_REG_CTRL, 32'h0002_0400, 4'b0111);  // Mode off, clear status
    bus_read(`RTC_REG_CTRL, rd);
    check_word("reg_rdata[ctrl]", 32'h0000_0400, rd);
    shadow[`RTC_REG_ALRM2] = alm;
    end_test("match alarm");
  endtask

  task automatic test_ctrl_outputs();
    reg_word_t data;
    for (int v = 0; v < 8; v++) begin
      data = 32'(v) << 10;
      bus_write(`RTC_REG_CTRL, data, 4'hF);
      check_bit("cfg_hmode", data[10], cfg_hmode);
      check_bit("cfg_rtc_halt", data[11], cfg_rtc_halt);
      check_bit("cfg_rtc_reset", data[12], cfg_rtc_reset);
    end
    bus_write(`RTC_REG_CTRL, 32'h0000_0400, 4'hF);
    end_test("control outputs");
  endtask

  initial begin
    rst_n      = 1'b0;
    reg_cs     = 1'b0;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    reg_be     = '0;
    inc_time_s = 1'b0;
    inc_time_m = 1'b0;
    inc_time_h = 1'b0;
    set_time('0);
    set_date('0);
    rng_state  = 32'd73989;
    for (int i = 0; i < 6; i++) shadow[i] = '0;
    shadow[`RTC_REG_CTRL] = 32'h0000_0400;  // 24-hour mode
    repeat (3) @(posedge rtc_clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_byte_writes();
    test_command();
    test_periodic();
    test_match();
    test_ctrl_outputs();
    $display("Checks passed: %0d, failed: %0d", n_pass, n_fail + proto_errs);
    if (n_fail + proto_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/rtc_reg_pkg.sv
design/rtc_time_pkg.sv
design/rtc_reg_file.sv
design/rtc_alarm_unit.sv
design/rtc_irq_ctrl.sv
design/rtc_reg_top.sv
tests/rtc_reg_checker.sv
tests/rtc_reg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RTC register block testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
  --top-module rtc_reg_tb -o rtc_sim || { echo "Build failed"; exit 1; }
./obj_dir/rtc_sim > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
